//--- design/nes_bus_pkg.sv
`default_nettype none

package nes_bus_pkg;

	typedef logic [15:0] addr_t; // CPU bus address
	typedef logic [7:0]  byte_t; // Data byte

	localparam int CPU_DIV = 12; // clk cycles per CPU cycle

	// Address map
	localparam addr_t OAM_DMA_ADDR  = 16'h4014; // Sprite DMA page register
	localparam addr_t OAM_DATA_ADDR = 16'h2004; // Sprite data port
	localparam addr_t IO_BASE       = 16'h4000; // Internal I/O window start
	localparam addr_t IO_END        = 16'h4018; // First address past the window
	localparam addr_t JOY1_ADDR     = 16'h4016;
	localparam addr_t JOY2_ADDR     = 16'h4017;

	// Bit 0 means CPU paused, bit 1 means DMA owns the bus
	typedef enum logic [1:0] {
		SPR_IDLE  = 2'b00,
		SPR_ALIGN = 2'b01, // Waiting for an odd read cycle
		SPR_RUN   = 2'b11  // Read/write pairs in progress
	} spr_state_t;

	typedef enum logic {
		DMC_IDLE    = 1'b0,
		DMC_PENDING = 1'b1 // Steal the next even cycle
	} dmc_state_t;

	typedef enum logic [1:0] {
		SRC_EXT  = 2'd0, // External memory
		SRC_JOY1 = 2'd1,
		SRC_JOY2 = 2'd2,
		SRC_OPEN = 2'd3  // Last value seen on the bus
	} rd_src_t;

endpackage

`default_nettype wire

//--- design/cycle_clock.sv
`timescale 1ns/1ps
`default_nettype none

// CPU cycle timing from the master clock
module cycle_clock
	import nes_bus_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,     // One clk pulse per CPU cycle
	output logic odd_cycle,  // 1 in odd CPU cycles
	output logic hold_reset  // Reset for the rest of the system
);

	logic [3:0] div_cnt; // Position inside the CPU cycle

	// Last clk of the CPU cycle
	assign cpu_ce = (div_cnt == 4'(CPU_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0; // Wrap at the cycle boundary
		end else begin
			div_cnt <= div_cnt + 4'd1;
		end
	end

	// Keep the system in reset until a cycle boundary
	always_ff @(posedge clk) begin
		if (reset) begin
			hold_reset <= 1'b1;
		end else if (cpu_ce) begin
			hold_reset <= 1'b0; // Released aligned to a CPU cycle
		end
	end

	// Even/odd phase, flips on every cycle boundary
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b1;
		end else if (cpu_ce) begin
			odd_cycle <= ~odd_cycle;
		end
	end

endmodule

`default_nettype wire

//--- design/dma_control.sv
`timescale 1ns/1ps
`default_nettype none

// Sprite and DMC DMA sequencing
// Sprite reads land on even cycles, writes to the sprite port on odd ones.
// A DMC fetch takes an even cycle; an interrupted sprite transfer drops back
// to alignment, so the odd cycle after the fetch stays idle
module dma_control
	import nes_bus_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic odd_cycle,
	input  logic cpu_rnw,        // CPU is in a read cycle
	input  logic sprite_trigger, // CPU wrote the page register
	input  logic dmc_trigger,    // DMC wants a byte
	input  logic page_end,       // Low address byte at FF
	output logic dma_enable,     // DMA owns the bus
	output logic dma_read,       // DMA direction, 1 = read
	output logic addr_step,      // Advance the page address
	output logic dmc_ack,        // DMC byte is on the bus this cycle
	output logic pause_cpu
);

	spr_state_t spr_state;
	dmc_state_t dmc_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= DMC_IDLE;
		end else if (cpu_ce) begin
			// DMC request is only taken while the CPU reads, on an even cycle
			case (dmc_state)
				DMC_IDLE:
					if (dmc_trigger && cpu_rnw && !odd_cycle)
						dmc_state <= DMC_PENDING;
				DMC_PENDING:
					if (!odd_cycle)
						dmc_state <= DMC_IDLE; // Ack cycle done
				default: dmc_state <= DMC_IDLE;
			endcase

			if (sprite_trigger) begin
				spr_state <= SPR_ALIGN; // Pause CPU, wait for phase
			end else begin
				case (spr_state)
					SPR_IDLE: ;
					SPR_ALIGN:
						if (cpu_rnw && odd_cycle)
							spr_state <= SPR_RUN; // Next cycle is an even read
					SPR_RUN:
						if (!odd_cycle && dmc_state == DMC_PENDING)
							spr_state <= SPR_ALIGN; // DMC took this read slot
						else if (odd_cycle && page_end)
							spr_state <= SPR_IDLE; // Byte FF written
					default: spr_state <= SPR_IDLE;
				endcase
			end
		end
	end

	assign dmc_ack    = (dmc_state == DMC_PENDING) && !odd_cycle;
	assign dma_enable = dmc_ack || (spr_state == SPR_RUN);
	assign dma_read   = !odd_cycle; // Reads even, writes odd
	assign addr_step  = (spr_state == SPR_RUN) && odd_cycle;
	assign pause_cpu  = (spr_state != SPR_IDLE) || dmc_trigger;

endmodule

`default_nettype wire

//--- design/oam_dma_path.sv
`timescale 1ns/1ps
`default_nettype none

// Sprite page address, data latch and bus source select
module oam_dma_path
	import nes_bus_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,
	input  logic  odd_cycle,
	input  logic  sprite_trigger,
	input  logic  addr_step,
	input  logic  dma_enable,
	input  logic  dma_read,
	input  logic  dmc_ack,
	input  logic  cpu_rnw,
	input  addr_t cpu_addr,
	input  addr_t dmc_addr,
	input  byte_t cpu_dout,
	input  byte_t cpu_din,    // Read data, also the DMA source
	output logic  page_end,
	output addr_t bus_addr,
	output byte_t bus_dout,
	output logic  bus_rnw
);

	addr_t page_addr; // Sprite source address
	byte_t spr_data;  // Byte on its way to the sprite port

	always_ff @(posedge clk) begin
		if (reset) begin
			page_addr <= '0;
		end else if (cpu_ce) begin
			if (sprite_trigger)
				page_addr <= {cpu_dout, 8'h00}; // New page, start at 00
			else if (addr_step)
				page_addr[7:0] <= page_addr[7:0] + 8'd1; // Page number stays
		end
	end

	// Capture on sprite read cycles only, DMC bytes go to the DMC
	always_ff @(posedge clk) begin
		if (cpu_ce && dma_enable && dma_read && !dmc_ack)
			spr_data <= cpu_din;
	end

	assign page_end = (page_addr[7:0] == 8'hFF);

	always_comb begin
		if (dmc_ack)
			bus_addr = dmc_addr;
		else if (dma_enable)
			bus_addr = odd_cycle ? OAM_DATA_ADDR : page_addr;
		else
			bus_addr = cpu_addr;
	end

	assign bus_dout = dma_enable ? spr_data : cpu_dout;
	assign bus_rnw  = dma_enable ? dma_read : cpu_rnw;

endmodule

`default_nettype wire

//--- design/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Decode of the shared bus
// I/O window 4000-4017 is internal, everything else goes to external memory
module bus_decode
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_ce,
	input  logic       bus_rnw,
	input  addr_t      bus_addr,
	input  byte_t      bus_dout,
	input  byte_t      ram_din,      // External memory data
	input  logic [4:0] joypad1_data,
	input  logic [4:0] joypad2_data,
	output byte_t      cpu_din,
	output logic       bus_read,
	output logic       bus_write,
	output logic       sprite_trigger,
	output logic [2:0] joypad_out,   // Strobe and expansion bits
	output logic [1:0] joypad_clock  // One bit per port
);

	logic    io_sel;   // Address in the internal window
	logic    joy1_sel;
	logic    joy2_sel;
	rd_src_t rd_src;
	byte_t   open_bus; // Last byte on the data bus

	assign io_sel   = (bus_addr >= IO_BASE) && (bus_addr < IO_END);
	assign joy1_sel = (bus_addr == JOY1_ADDR);
	assign joy2_sel = (bus_addr == JOY2_ADDR);

	always_comb begin
		if (!io_sel)
			rd_src = SRC_EXT;
		else if (joy1_sel)
			rd_src = SRC_JOY1;
		else if (joy2_sel)
			rd_src = SRC_JOY2;
		else
			rd_src = SRC_OPEN; // Unmapped I/O, 4015 included
	end

	// Pads only drive the low five bits
	always_comb begin
		case (rd_src)
			SRC_EXT:  cpu_din = ram_din;
			SRC_JOY1: cpu_din = {open_bus[7:5], joypad1_data};
			SRC_JOY2: cpu_din = {open_bus[7:5], joypad2_data};
			default:  cpu_din = open_bus;
		endcase
	end

	// External strobes, one clk per CPU cycle
	assign bus_read  = cpu_ce && bus_rnw && !io_sel;
	assign bus_write = cpu_ce && !bus_rnw && !io_sel;

	assign sprite_trigger = cpu_ce && !bus_rnw && (bus_addr == OAM_DMA_ADDR);

	// Pad shift clocks on reads
	assign joypad_clock = {cpu_ce && bus_rnw && joy2_sel,
		cpu_ce && bus_rnw && joy1_sel};

	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_out <= '0;
		end else if (cpu_ce && !bus_rnw && joy1_sel) begin
			joypad_out <= bus_dout[2:0]; // Bit 0 is the pad strobe
		end
	end

	// Bus keeps its last value when nothing drives it
	always_ff @(posedge clk) begin
		if (cpu_ce)
			open_bus <= cpu_din;
	end

endmodule

`default_nettype wire

//--- design/nes_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

// CPU-side bus with sprite and DMC DMA
module nes_bus_top
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  addr_t      cpu_addr,
	input  addr_t      dmc_addr,
	input  logic       cpu_rnw,
	input  logic       dmc_trigger,
	input  byte_t      cpu_dout,
	input  byte_t      ram_din,
	input  logic [4:0] joypad1_data,
	input  logic [4:0] joypad2_data,
	output byte_t      cpu_din,
	output byte_t      bus_dout,
	output addr_t      bus_addr,
	output logic       bus_read,
	output logic       bus_write,
	output logic       cpu_ce,
	output logic       pause_cpu,
	output logic       dmc_ack,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);

	logic odd_cycle;
	logic hold_reset;     // Cycle-aligned system reset
	logic dma_enable;
	logic dma_read;
	logic addr_step;
	logic page_end;
	logic sprite_trigger;
	logic bus_rnw;        // Direction after the DMA mux

	cycle_clock u_cycle_clock (
		.clk        (clk),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.odd_cycle  (odd_cycle),
		.hold_reset (hold_reset)
	);

	dma_control u_dma_control (
		.clk            (clk),
		.reset          (hold_reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.cpu_rnw        (cpu_rnw),        // CPU side, not the muxed bus
		.sprite_trigger (sprite_trigger),
		.dmc_trigger    (dmc_trigger),
		.page_end       (page_end),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.addr_step      (addr_step),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	oam_dma_path u_oam_dma_path (
		.clk            (clk),
		.reset          (hold_reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.addr_step      (addr_step),
		.dma_enable     (dma_enable),
		.dma_read       (dma_read),
		.dmc_ack        (dmc_ack),
		.cpu_rnw        (cpu_rnw),
		.cpu_addr       (cpu_addr),
		.dmc_addr       (dmc_addr),
		.cpu_dout       (cpu_dout),
		.cpu_din        (cpu_din),        // Read data feeds the sprite latch
		.page_end       (page_end),
		.bus_addr       (bus_addr),
		.bus_dout       (bus_dout),
		.bus_rnw        (bus_rnw)
	);

	bus_decode u_bus_decode (
		.clk            (clk),
		.reset          (hold_reset),
		.cpu_ce         (cpu_ce),
		.bus_rnw        (bus_rnw),
		.bus_addr       (bus_addr),
		.bus_dout       (bus_dout),
		.ram_din        (ram_din),
		.joypad1_data   (joypad1_data),
		.joypad2_data   (joypad2_data),
		.cpu_din        (cpu_din),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.sprite_trigger (sprite_trigger),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

endmodule

`default_nettype wire

//--- verification/nes_bus_chk.sv
`timescale 1ns/1ps
`default_nettype none

// DMA sequencing rules, bound into dma_control
module nes_bus_chk
	import nes_bus_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic odd_cycle,
	input logic cpu_rnw,
	input logic sprite_trigger,
	input logic dmc_trigger,
	input logic pause_cpu,
	input logic dmc_ack,
	input logic dma_enable,
	input logic dma_read
);

	// CPU stops right after the page register write
	assert property (@(posedge clk) disable iff (reset) sprite_trigger |=> pause_cpu)
		else $error("pause_cpu did not rise after sprite trigger");

	// Ack lands on the even cycle after the one that took the request
	assert property (@(posedge clk) disable iff (reset)
		cpu_ce && dmc_ack |->
			$past(cpu_ce && dmc_trigger && cpu_rnw && !odd_cycle && !dmc_ack, 2 * CPU_DIV))
		else $error("dmc_ack without a DMC request on the even cycle before");

	// Sprite write only right after a sprite read, never after a DMC fetch
	assert property (@(posedge clk) disable iff (reset)
		cpu_ce && dma_enable && !dma_read |->
			$past(dma_enable && dma_read && !dmc_ack, CPU_DIV))
		else $error("DMA write without a sprite read in the cycle before");

endmodule

bind dma_control nes_bus_chk u_chk (
	.clk            (clk),
	.reset          (reset),
	.cpu_ce         (cpu_ce),
	.odd_cycle      (odd_cycle),
	.cpu_rnw        (cpu_rnw),
	.sprite_trigger (sprite_trigger),
	.dmc_trigger    (dmc_trigger),
	.pause_cpu      (pause_cpu),
	.dmc_ack        (dmc_ack),
	.dma_enable     (dma_enable),
	.dma_read       (dma_read)
);

`default_nettype wire

//--- verification/nes_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Plays the CPU, external memory and DMC unit around nes_bus_top
module nes_bus_tb
	import nes_bus_pkg::*;
();

	logic       clk;
	logic       reset;
	addr_t      cpu_addr;
	addr_t      dmc_addr;
	logic       cpu_rnw;
	logic       dmc_trigger;
	byte_t      cpu_dout;
	byte_t      ram_din;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	byte_t      cpu_din;
	byte_t      bus_dout;
	addr_t      bus_addr;
	logic       bus_read;
	logic       bus_write;
	logic       cpu_ce;
	logic       pause_cpu;
	logic       dmc_ack;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;
	byte_t      mem [0:65535]; // External memory model
	integer     seed;

	nes_bus_top UUT (.*);

	assign ram_din = mem[bus_addr]; // Asynchronous read
	always @(posedge clk) begin
		if (bus_write)
			mem[bus_addr] <= bus_dout;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got == exp)
			else report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	// Stops at the falling edge where cpu_ce is high, bus outputs are settled there
	task wait_ce();
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_ce) begin
			n++;
			if (n > 2 * CPU_DIV)
				report_failure("cpu_ce did not arrive in time");
			@(negedge clk);
		end
	endtask

	task end_cycle(); // First falling edge of the next CPU cycle
		@(negedge clk);
	endtask

	task cpu_cycle(input addr_t a, input logic rnw, input byte_t d);
		cpu_addr = a;
		cpu_rnw  = rnw;
		cpu_dout = d;
		wait_ce();
	endtask

	task align_even();
		int n;
		n = 0;
		while (UUT.u_cycle_clock.odd_cycle) begin
			cpu_cycle(16'h0000, 1'b1, 8'h00); // Idle read
			end_cycle();
			n++;
			if (n > 4)
				report_failure("even cycle never came");
		end
	endtask

	task check_dmc_read(input addr_t a);
		check_val("bus_addr", bus_addr, a);
		check_val("bus_read", 16'(bus_read), 16'h1);
		check_val("cpu_din", 16'(cpu_din), 16'(mem[a]));
	endtask

	task test_reset();
		int n;
		check_val("pause_cpu", 16'(pause_cpu), 16'h0);
		check_val("dmc_ack", 16'(dmc_ack), 16'h0);
		check_val("bus_read", 16'(bus_read), 16'h0);
		check_val("bus_write", 16'(bus_write), 16'h0);
		check_val("joypad_clock", 16'(joypad_clock), 16'h0);
		check_val("joypad_out", 16'(joypad_out), 16'h0);
		check_val("odd_cycle", 16'(UUT.u_cycle_clock.odd_cycle), 16'h1);
		wait_ce(); // First boundary, system leaves reset
		n = 1;
		@(negedge clk);
		while (!cpu_ce && n < 2 * CPU_DIV) begin
			n++;
			@(negedge clk);
		end
		check_val("cpu_ce period", 16'(n), 16'(CPU_DIV)); // clk count between boundaries
		end_cycle();
	endtask

	task test_plain();
		byte_t exp;
		cpu_cycle(16'h0123, 1'b0, 8'hA5);
		check_val("bus_write", 16'(bus_write), 16'h1);
		check_val("bus_addr", bus_addr, 16'h0123);
		check_val("bus_dout", 16'(bus_dout), 16'h00A5);
		end_cycle();
		cpu_cycle(16'h0123, 1'b1, 8'h00); // Read back
		check_val("bus_read", 16'(bus_read), 16'h1);
		check_val("cpu_din", 16'(cpu_din), 16'h00A5);
		end_cycle();
		cpu_cycle(16'h0456, 1'b1, 8'h00);
		exp = mem[16'h0456];
		check_val("cpu_din", 16'(cpu_din), 16'(exp));
		end_cycle();
		cpu_cycle(16'h4000, 1'b1, 8'h00); // Open bus keeps the last byte
		check_val("bus_read", 16'(bus_read), 16'h0);
		check_val("cpu_din", 16'(cpu_din), 16'(exp));
		end_cycle();
	endtask

	// Sprite page copy, optionally with one DMC fetch in the middle
	task test_sprite(input byte_t page, input logic steal, input addr_t dmc_a);
		logic [8:0] count;
		int         acks;
		int         n;
		logic       acked;
		addr_t      last_rd;
		cpu_cycle(OAM_DMA_ADDR, 1'b0, page);
		end_cycle();
		check_val("pause_cpu", 16'(pause_cpu), 16'h1);
		cpu_addr = 16'h0000; // Hold a read while paused
		cpu_rnw  = 1'b1;
		count    = '0;
		acks     = 0;
		n        = 0;
		last_rd  = '0;
		while (pause_cpu) begin
			if (steal && count == 9'd100 && !dmc_trigger && acks == 0 &&
				!UUT.u_cycle_clock.odd_cycle) begin
				dmc_addr    = dmc_a;
				dmc_trigger = 1'b1;
			end
			wait_ce();
			acked = dmc_ack;
			if (dmc_ack) begin
				check_dmc_read(dmc_a);
				acks++;
			end
			if (bus_read)
				last_rd = bus_addr;
			if (bus_write) begin
				check_val("bus_addr", bus_addr, OAM_DATA_ADDR);
				check_val("read address", last_rd, {page, count[7:0]});
				check_val("bus_dout", 16'(bus_dout), 16'(mem[{page, count[7:0]}]));
				count++;
			end
			end_cycle();
			if (acked)
				dmc_trigger = 1'b0; // Byte received
			n++;
			if (n > 700)
				report_failure("sprite DMA did not finish");
		end
		check_val("sprite writes", 16'(count), 16'h0100);
		if (steal)
			check_val("dmc_ack count", 16'(acks), 16'h1);
	endtask

	task test_dmc(input addr_t a);
		int   acks;
		logic acked;
		acks = 0;
		align_even();
		dmc_addr    = a;
		dmc_trigger = 1'b1;
		for (int i = 0; i < 6; i++) begin // Ack due two cycles later, rest checks for repeats
			cpu_cycle(16'h0000, 1'b1, 8'h00);
			acked = dmc_ack;
			if (dmc_ack) begin
				check_dmc_read(a);
				acks++;
			end
			end_cycle();
			if (acked)
				dmc_trigger = 1'b0;
		end
		check_val("dmc_ack count", 16'(acks), 16'h1);
	endtask

	task test_joypad();
		logic [2:0] top;
		cpu_cycle(JOY1_ADDR, 1'b0, 8'h05);
		end_cycle();
		check_val("joypad_out", 16'(joypad_out), 16'h5);
		cpu_cycle(16'h0456, 1'b1, 8'h00); // Known open bus value
		top = mem[16'h0456][7:5];
		end_cycle();
		cpu_cycle(JOY1_ADDR, 1'b1, 8'h00);
		check_val("joypad_clock", 16'(joypad_clock), 16'h1);
		check_val("cpu_din", 16'(cpu_din), 16'({top, joypad1_data}));
		end_cycle();
		cpu_cycle(JOY2_ADDR, 1'b1, 8'h00);
		check_val("joypad_clock", 16'(joypad_clock), 16'h2);
		check_val("cpu_din", 16'(cpu_din), 16'({top, joypad2_data}));
		end_cycle();
	endtask

	initial begin
		reset        = 1'b1;
		cpu_addr     = 16'h0000;
		dmc_addr     = 16'h0000;
		cpu_rnw      = 1'b1;
		dmc_trigger  = 1'b0;
		cpu_dout     = 8'h00;
		joypad1_data = 5'h0A;
		joypad2_data = 5'h13;
		seed         = 44;
		for (int i = 0; i < 65536; i++)
			mem[i] <= 8'($random(seed));
		repeat (16) @(negedge clk);
		reset = 1'b0;
		test_reset();
		test_plain();
		test_sprite(8'h03, 1'b0, 16'h0000);
		test_dmc(16'hC123);
		test_sprite(8'h05, 1'b1, 16'hD0F0);
		test_joypad();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/nes_bus_pkg.sv
design/cycle_clock.sv
design/dma_control.sv
design/oam_dma_path.sv
design/bus_decode.sv
design/nes_bus_top.sv
verification/nes_bus_chk.sv
verification/nes_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module nes_bus_tb -f verilog.f \
	-o nes_bus_sim > build.log 2>&1 \
	&& ./obj_dir/nes_bus_sim > sim.log 2>&1 \
	|| echo "Simulation finished: FAIL" >> sim.log
cat build.log sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
